// ==== logic/pad_pkg.sv ====
// Shared definitions for the joypad port subsystem.
// Holds the multitap pad count, the button vector layout, the pad mode
// encoding and the mouse idle limit. Modules refer to these by scoped
// names, so the package is compiled before any RTL file.

package pad_pkg;

	////////////////////
	// Multitap layout
	////////////////////

	localparam int PAD_COUNT = 5;
	localparam int PAD_BITS  = 12;
	localparam int PORT_BITS = 3;

	// Nibble width on the console data lines
	localparam int NIBBLE_BITS = 4;

	////////////////////
	// Button bit order
	////////////////////

	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_I      = 4;
	localparam int BTN_II     = 5;
	localparam int BTN_SELECT = 6;
	localparam int BTN_RUN    = 7;
	localparam int BTN_III    = 8;
	localparam int BTN_IV     = 9;
	localparam int BTN_V      = 10;
	localparam int BTN_VI     = 11;

	// One button vector per pad, active high
	typedef logic [PAD_COUNT-1:0][PAD_BITS-1:0] pad_buttons_t;

	// Controller type selected for all pads
	typedef enum logic [1:0] {
		MODE_TWO_BUTTON = 2'd0,
		MODE_TURBO      = 2'd1,
		MODE_SIX_BUTTON = 2'd2
	} pad_mode_t;

	// Clear-low cycles before the mouse read sequence restarts
	localparam int MOUSE_IDLE_CYCLES = 32767;

	// Ports with no pad behind them
	localparam logic [15:0] UNUSED_PORT_WORD = 16'h0FFF;

endpackage

// ==== logic/pad_turbo.sv ====
// Autofire generator for buttons I and II of every multitap pad.
// A small scan counter steps once per read sequence (rising edge of clear);
// buttons III/V and IV/VI add repeating presses to I and II at two rates.
// The repeat bits are only updated at that edge, so they stay steady
// through a whole read sequence.

module pad_turbo (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              pad_clr,
	input  pad_pkg::pad_buttons_t             pads,
	output logic [pad_pkg::PAD_COUNT-1:0]     turbo_i,
	output logic [pad_pkg::PAD_COUNT-1:0]     turbo_ii
);

	logic       clr_q;
	logic       clr_rise;
	logic [2:0] scan_cnt;

	assign clr_rise = pad_clr & ~clr_q;

	////////////////////
	// Scan counter and repeat bits
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_q    <= 1'b0;
			scan_cnt <= 3'd0;
			turbo_i  <= '0;
			turbo_ii <= '0;
		end else begin
			clr_q <= pad_clr;
			if (clr_rise) begin
				scan_cnt <= scan_cnt + 3'd1;
				// Old counter value sets the repeat phase
				for (int p = 0; p < pad_pkg::PAD_COUNT; p++) begin
					turbo_i[p] <= pads[p][pad_pkg::BTN_I]
						| (pads[p][pad_pkg::BTN_III] & scan_cnt[2])
						| (pads[p][pad_pkg::BTN_V] & scan_cnt[1]);
					turbo_ii[p] <= pads[p][pad_pkg::BTN_II]
						| (pads[p][pad_pkg::BTN_IV] & scan_cnt[2])
						| (pads[p][pad_pkg::BTN_VI] & scan_cnt[1]);
				end
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Repeat bits hold steady between read sequences
	turbo_steady: assert property (
		@(posedge clk_sys) disable iff (reset)
		!clr_rise |=> $stable({turbo_i, turbo_ii})
	);

endmodule

// ==== logic/mouse_tracker.sv ====
// Mouse motion sequencer for the joypad port.
// Motion arrives with a toggling strobe and is held as pending X/Y.
// Each rising edge of clear steps a 2-bit nibble index; after the fourth
// nibble the pending motion moves to the shown registers and is cleared.
// If clear stays low long enough the index is parked at 3, so the next
// sequence starts fresh at nibble 0 with new motion.

module mouse_tracker (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              pad_clr,
	input  logic                              mouse_strobe,
	input  logic [7:0]                        mouse_dx,
	input  logic [7:0]                        mouse_dy,
	output logic [pad_pkg::NIBBLE_BITS-1:0]   mouse_nibble
);

	logic                                              clr_q;
	logic                                              strobe_q;
	logic [1:0]                                        nib_idx;
	logic [$clog2(pad_pkg::MOUSE_IDLE_CYCLES + 1)-1:0] idle_cnt;
	logic [7:0]                                        pend_x;
	logic [7:0]                                        pend_y;
	logic [7:0]                                        shown_x;
	logic [7:0]                                        shown_y;

	////////////////////
	// Idle timeout
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
		end else if (pad_clr) begin
			idle_cnt <= '0;
		end else if (idle_cnt != pad_pkg::MOUSE_IDLE_CYCLES) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	////////////////////
	// Motion capture and nibble index
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_q    <= 1'b0;
			strobe_q <= 1'b0;
			nib_idx  <= 2'd0;
			pend_x   <= 8'd0;
			pend_y   <= 8'd0;
			shown_x  <= 8'd0;
			shown_y  <= 8'd0;
		end else begin
			clr_q    <= pad_clr;
			strobe_q <= mouse_strobe;

			// Host stopped reading so the next edge restarts the sequence
			if (idle_cnt == pad_pkg::MOUSE_IDLE_CYCLES) begin
				nib_idx <= 2'd3;
			end

			if (pad_clr && !clr_q) begin
				nib_idx <= nib_idx + 2'd1;
				if (nib_idx == 2'd3) begin
					shown_x <= pend_x;
					shown_y <= pend_y;
					pend_x  <= 8'd0;
					pend_y  <= 8'd0;
				end
			end

			// New motion wins over the clear of pending values
			if (mouse_strobe != strobe_q) begin
				pend_x <= 8'd0 - mouse_dx;
				pend_y <= mouse_dy;
			end
		end
	end

	// X high, X low, Y high, Y low
	always_comb begin
		case (nib_idx)
			2'd0:    mouse_nibble = shown_x[7:4];
			2'd1:    mouse_nibble = shown_x[3:0];
			2'd2:    mouse_nibble = shown_y[7:4];
			default: mouse_nibble = shown_y[3:0];
		endcase
	end

	// Idle count holds at its limit and keeps the index parked
	idle_parks_index: assert property (
		@(posedge clk_sys) disable iff (reset)
		idle_cnt == pad_pkg::MOUSE_IDLE_CYCLES && !pad_clr
			|=> idle_cnt == pad_pkg::MOUSE_IDLE_CYCLES && nib_idx == 2'd3
	);

endmodule

// ==== logic/tap_scanner.sv ====
// Multitap scanner and data nibble register.
// Select edges step the port counter while clear is low; clear high resets
// the port and drives the data lines to zero. Each port returns a 16-bit
// active-low word, and the nibble picked by the bank flag and the select
// line is registered to the console.

module tap_scanner (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              pad_sel,
	input  logic                              pad_clr,
	input  pad_pkg::pad_buttons_t             pads,
	input  pad_pkg::pad_mode_t                mode,
	input  logic                              multitap_en,
	input  logic                              mouse_en,
	input  logic [pad_pkg::PAD_COUNT-1:0]     turbo_i,
	input  logic [pad_pkg::PAD_COUNT-1:0]     turbo_ii,
	input  logic [pad_pkg::NIBBLE_BITS-1:0]   mouse_nibble,
	input  logic                              mouse_left,
	input  logic                              mouse_right,
	output logic [pad_pkg::NIBBLE_BITS-1:0]   pad_data
);

	logic                          clr_q;
	logic                          sel_q;
	logic                          bank;
	logic [pad_pkg::PORT_BITS-1:0] port;
	logic [15:0]                   port_word;
	logic [7:0]                    mouse_byte;

	// Active-low pad word, top nibble always reads as zero
	function automatic logic [15:0] pad_word(
		input logic [pad_pkg::PAD_BITS-1:0] b,
		input logic                         btn_i,
		input logic                         btn_ii
	);
		pad_word = ~{4'hF,
			b[pad_pkg::BTN_VI], b[pad_pkg::BTN_V], b[pad_pkg::BTN_IV], b[pad_pkg::BTN_III],
			b[pad_pkg::BTN_LEFT], b[pad_pkg::BTN_DOWN], b[pad_pkg::BTN_RIGHT], b[pad_pkg::BTN_UP],
			b[pad_pkg::BTN_RUN], b[pad_pkg::BTN_SELECT], btn_ii, btn_i};
	endfunction

	// Mouse shares run and select with pad 0
	assign mouse_byte = {mouse_nibble, ~{pads[0][pad_pkg::BTN_RUN], pads[0][pad_pkg::BTN_SELECT],
		mouse_left, mouse_right}};

	////////////////////
	// Word for current port
	////////////////////

	always_comb begin
		port_word = pad_pkg::UNUSED_PORT_WORD;
		for (int p = 0; p < pad_pkg::PAD_COUNT; p++) begin
			if (port == pad_pkg::PORT_BITS'(p)) begin
				if (mode == pad_pkg::MODE_TURBO) begin
					port_word = pad_word(pads[p], turbo_i[p], turbo_ii[p]);
				end else begin
					port_word = pad_word(pads[p], pads[p][pad_pkg::BTN_I],
						pads[p][pad_pkg::BTN_II]);
				end
			end
		end
		if (mouse_en && port == '0) begin
			port_word = {mouse_byte, mouse_byte};
		end
	end

	////////////////////
	// Port counter, bank and data latch
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_q    <= 1'b0;
			sel_q    <= 1'b0;
			bank     <= 1'b0;
			port     <= '0;
			pad_data <= '0;
		end else begin
			clr_q    <= pad_clr;
			sel_q    <= pad_sel;
			pad_data <= port_word[{bank, pad_sel, 2'b00} +: pad_pkg::NIBBLE_BITS];

			if (pad_clr) begin
				port     <= '0;
				pad_data <= '0;
				// 6-button pads swap banks every read sequence
				if (!clr_q && mode == pad_pkg::MODE_SIX_BUTTON) begin
					bank <= ~bank;
				end
			end else if (pad_sel && !sel_q && (multitap_en || mouse_en)) begin
				port <= port + 1'b1;
			end
		end
	end

	port_cleared: assert property (
		@(posedge clk_sys) disable iff (reset)
		pad_clr |=> port == '0
	);

endmodule

// ==== logic/pad_port_top.sv ====
// Joypad port top level.
// Answers the console's select and clear lines with an active-low nibble.
// Joins the turbo generator, the mouse sequencer and the multitap scanner;
// pad type, multitap and mouse are chosen on the setting inputs.

module pad_port_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              pad_sel,
	input  logic                              pad_clr,
	input  pad_pkg::pad_buttons_t             pads,
	input  pad_pkg::pad_mode_t                mode,
	input  logic                              multitap_en,
	input  logic                              mouse_en,
	input  logic                              mouse_strobe,
	input  logic [7:0]                        mouse_dx,
	input  logic [7:0]                        mouse_dy,
	input  logic                              mouse_left,
	input  logic                              mouse_right,
	output logic [pad_pkg::NIBBLE_BITS-1:0]   pad_data
);

	logic [pad_pkg::PAD_COUNT-1:0]   turbo_i;
	logic [pad_pkg::PAD_COUNT-1:0]   turbo_ii;
	logic [pad_pkg::NIBBLE_BITS-1:0] mouse_nibble;

	pad_turbo u_turbo (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pad_clr  (pad_clr),
		.pads     (pads),
		.turbo_i  (turbo_i),
		.turbo_ii (turbo_ii)
	);

	mouse_tracker u_mouse (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_clr      (pad_clr),
		.mouse_strobe (mouse_strobe),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_nibble (mouse_nibble)
	);

	tap_scanner u_scanner (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_sel      (pad_sel),
		.pad_clr      (pad_clr),
		.pads         (pads),
		.mode         (mode),
		.multitap_en  (multitap_en),
		.mouse_en     (mouse_en),
		.turbo_i      (turbo_i),
		.turbo_ii     (turbo_ii),
		.mouse_nibble (mouse_nibble),
		.mouse_left   (mouse_left),
		.mouse_right  (mouse_right),
		.pad_data     (pad_data)
	);

endmodule

// ==== verification/tb_pad_port.sv ====
// Testbench for the joypad port top level.
// Drives select and clear like the console does, with random pads and mouse
// motion from a fixed seed, and checks every nibble against a step model.
// Covers multitap scan, six-button banks, turbo, mouse and mouse timeout.

module tb_pad_port;

	logic                                clk_sys;
	logic                                reset;
	logic                                pad_sel;
	logic                                pad_clr;
	pad_pkg::pad_buttons_t               pads;
	pad_pkg::pad_mode_t                  mode;
	logic                                multitap_en;
	logic                                mouse_en;
	logic                                mouse_strobe;
	logic [7:0]                          mouse_dx;
	logic [7:0]                          mouse_dy;
	logic                                mouse_left;
	logic                                mouse_right;
	logic [pad_pkg::NIBBLE_BITS-1:0]     pad_data;

	int errors;
	int checks;
	int seed;

	// Model state
	int                                  m_port;
	logic                                m_bank;
	logic [2:0]                          m_tcnt;
	logic [pad_pkg::PAD_COUNT-1:0]       m_ti;
	logic [pad_pkg::PAD_COUNT-1:0]       m_tii;
	logic [1:0]                          m_idx;
	logic [7:0]                          m_pend_x;
	logic [7:0]                          m_pend_y;
	logic [7:0]                          m_shown_x;
	logic [7:0]                          m_shown_y;

	pad_port_top u_pad_port_top (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_sel      (pad_sel),
		.pad_clr      (pad_clr),
		.pads         (pads),
		.mode         (mode),
		.multitap_en  (multitap_en),
		.mouse_en     (mouse_en),
		.mouse_strobe (mouse_strobe),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_left   (mouse_left),
		.mouse_right  (mouse_right),
		.pad_data     (pad_data)
	);

	always #50 clk_sys = ~clk_sys;

	////////////////////
	// Model
	////////////////////

	// Turbo phase, mouse index and button bank step at a clear rising edge
	task automatic model_clear_rise();
		for (int p = 0; p < pad_pkg::PAD_COUNT; p++) begin
			m_ti[p] = pads[p][pad_pkg::BTN_I] | (pads[p][pad_pkg::BTN_III] & m_tcnt[2])
				| (pads[p][pad_pkg::BTN_V] & m_tcnt[1]);
			m_tii[p] = pads[p][pad_pkg::BTN_II] | (pads[p][pad_pkg::BTN_IV] & m_tcnt[2])
				| (pads[p][pad_pkg::BTN_VI] & m_tcnt[1]);
		end
		m_tcnt = m_tcnt + 3'd1;
		if (m_idx == 2'd3) begin
			m_shown_x = m_pend_x;
			m_shown_y = m_pend_y;
			m_pend_x  = 8'd0;
			m_pend_y  = 8'd0;
		end
		m_idx = m_idx + 2'd1;
		if (mode == pad_pkg::MODE_SIX_BUTTON) begin
			m_bank = ~m_bank;
		end
	endtask

	function automatic logic [3:0] expected_nibble(input int port, input logic sel);
		logic [pad_pkg::PAD_BITS-1:0] b;
		logic                         btn_i;
		logic                         btn_ii;
		logic [7:0]                   shown;
		if (mouse_en && port == 0) begin
			shown = m_idx[1] ? m_shown_y : m_shown_x;
			b = pads[0];
			if (sel) begin
				return m_idx[0] ? shown[3:0] : shown[7:4];
			end
			return ~{b[pad_pkg::BTN_RUN], b[pad_pkg::BTN_SELECT], mouse_left, mouse_right};
		end
		// Empty ports read F, F, F, 0
		if (port >= pad_pkg::PAD_COUNT) begin
			return (m_bank && sel) ? 4'h0 : 4'hF;
		end
		b = pads[port];
		btn_i  = (mode == pad_pkg::MODE_TURBO) ? m_ti[port] : b[pad_pkg::BTN_I];
		btn_ii = (mode == pad_pkg::MODE_TURBO) ? m_tii[port] : b[pad_pkg::BTN_II];
		case ({m_bank, sel})
			2'b00: return ~{b[pad_pkg::BTN_RUN], b[pad_pkg::BTN_SELECT], btn_ii, btn_i};
			2'b01: return ~{b[pad_pkg::BTN_LEFT], b[pad_pkg::BTN_DOWN],
				b[pad_pkg::BTN_RIGHT], b[pad_pkg::BTN_UP]};
			2'b10: return ~{b[pad_pkg::BTN_VI], b[pad_pkg::BTN_V],
				b[pad_pkg::BTN_IV], b[pad_pkg::BTN_III]};
			default: return 4'h0;
		endcase
	endfunction

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
		end
	endtask

	task automatic check_data(input logic [3:0] exp);
		checks++;
		assert (pad_data === exp) else begin
			errors++;
			$display("error: time %0t signal pad_data expected %h actual %h", $time, exp, pad_data);
		end
	endtask

	// One change on select or clear and two cycles for the registered nibble
	task automatic drive_step(input logic sel, input logic clr);
		logic [3:0] exp;
		@(posedge clk_sys);
		#10;
		if (clr && !pad_clr) begin
			model_clear_rise();
		end
		if (clr) begin
			m_port = 0;
		end else if (sel && !pad_sel && (multitap_en || mouse_en)) begin
			m_port = (m_port + 1) % 8;
		end
		pad_sel = sel;
		pad_clr = clr;
		exp = clr ? 4'h0 : expected_nibble(m_port, sel);
		wait_cycles(2);
		@(negedge clk_sys);
		check_data(exp);
	endtask

	task automatic read_sequence(input int ports);
		if (!pad_sel) begin
			drive_step(1'b1, pad_clr);
		end
		drive_step(1'b1, 1'b1);
		drive_step(1'b1, 1'b0);
		drive_step(1'b0, 1'b0);
		for (int n = 1; n < ports; n++) begin
			drive_step(1'b1, 1'b0);
			drive_step(1'b0, 1'b0);
		end
	endtask

	task automatic randomize_pads();
		@(posedge clk_sys);
		#10;
		for (int p = 0; p < pad_pkg::PAD_COUNT; p++) begin
			pads[p] = pad_pkg::PAD_BITS'($urandom);
		end
	endtask

	task automatic configure(input pad_pkg::pad_mode_t m, input logic tap, input logic mouse);
		@(posedge clk_sys);
		#10;
		mode        = m;
		multitap_en = tap;
		mouse_en    = mouse;
	endtask

	task automatic new_mouse_motion();
		@(posedge clk_sys);
		#10;
		mouse_dx     = 8'($urandom);
		mouse_dy     = 8'($urandom);
		mouse_left   = 1'($urandom);
		mouse_right  = 1'($urandom);
		mouse_strobe = ~mouse_strobe;
		m_pend_x     = ~mouse_dx + 8'd1;
		m_pend_y     = mouse_dy;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		seed = 7;
		void'($urandom(seed));
		errors = 0;
		checks = 0;
		clk_sys = 1'b0;
		reset = 1'b1;
		pad_sel = 1'b0;
		pad_clr = 1'b0;
		pads = '0;
		mode = pad_pkg::MODE_TWO_BUTTON;
		multitap_en = 1'b1;
		mouse_en = 1'b0;
		mouse_strobe = 1'b0;
		mouse_dx = 8'd0;
		mouse_dy = 8'd0;
		mouse_left = 1'b0;
		mouse_right = 1'b0;
		m_port = 0;
		m_bank = 1'b0;
		m_tcnt = 3'd0;
		m_ti = '0;
		m_tii = '0;
		m_idx = 2'd0;
		m_pend_x = 8'd0;
		m_pend_y = 8'd0;
		m_shown_x = 8'd0;
		m_shown_y = 8'd0;

		// Reset and clear
		wait_cycles(4);
		#10;
		reset = 1'b0;
		@(negedge clk_sys);
		check_data(4'h0);
		randomize_pads();
		drive_step(pad_sel, 1'b1);
		drive_step(pad_sel, 1'b0);

		// Two-button multitap with empty ports 5 and 6
		for (int i = 0; i < 4; i++) begin
			randomize_pads();
			read_sequence(7);
		end

		// Six-button banks alternate per read sequence
		configure(pad_pkg::MODE_SIX_BUTTON, 1'b1, 1'b0);
		for (int i = 0; i < 6; i++) begin
			randomize_pads();
			read_sequence(5);
		end

		configure(pad_pkg::MODE_TURBO, 1'b1, 1'b0);
		for (int i = 0; i < 8; i++) begin
			randomize_pads();
			read_sequence(3);
		end

		// Mouse on port 0 with one nibble per read sequence
		configure(pad_pkg::MODE_TWO_BUTTON, 1'b0, 1'b1);
		for (int i = 0; i < 12; i++) begin
			if (i % 4 == 0) begin
				new_mouse_motion();
			end
			randomize_pads();
			read_sequence(2);
		end

		// Host stops reading and the index parks at 3
		new_mouse_motion();
		read_sequence(1);
		new_mouse_motion();
		wait_cycles(pad_pkg::MOUSE_IDLE_CYCLES + 8);
		m_idx = 2'd3;
		for (int i = 0; i < 4; i++) begin
			read_sequence(1);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/pad_pkg.sv
logic/pad_turbo.sv
logic/mouse_tracker.sv
logic/tap_scanner.sv
logic/pad_port_top.sv
verification/tb_pad_port.sv
